// ==== compile.f ====
rtl/core_pkg.sv
rtl/decode_if.sv
rtl/decoder_2ri8.sv
rtl/decoder_3r.sv
rtl/decoder_2ri12.sv
rtl/id_stage.sv
rtl/gpr_file.sv
rtl/alu.sv
rtl/fetch_wb.sv
rtl/la_core_top.sv
test/tb_top.sv

// ==== rtl/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  core_pkg::alu_op_e  op_i,
    input  core_pkg::alu_sel_e sel_i,
    input  core_pkg::data_t    a_i,
    input  core_pkg::data_t    b_i,
    output core_pkg::data_t    result_o
);

    import core_pkg::*;

    logic [4:0] shamt;
    data_t      arith_res;
    data_t      logic_res;
    data_t      shift_res;

    assign shamt = b_i[4:0];

    always_comb begin
        arith_res = (op_i == ALU_SUB) ? (a_i - b_i) : (a_i + b_i);

        case (op_i)
            ALU_AND: logic_res = a_i & b_i;
            ALU_OR:  logic_res = a_i | b_i;
            default: logic_res = a_i ^ b_i;
        endcase

        case (op_i)
            ALU_SRL: shift_res = a_i >> shamt;
            ALU_SRA: shift_res = data_t'($signed(a_i) >>> shamt);
            default: shift_res = a_i << shamt;
        endcase
    end

    // result class picks the group
    always_comb begin
        case (sel_i)
            SEL_ARITH: result_o = arith_res;
            SEL_LOGIC: result_o = logic_res;
            default:   result_o = shift_res;
        endcase
    end

endmodule

// ==== rtl/core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 32;
    localparam int GPR_NUM    = 32;
    localparam int REG_ADDR_W = $clog2(GPR_NUM);

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [31:0]           instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // operation inside a result class
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // result class, picks the ALU output group
    typedef enum logic [1:0] {
        SEL_ARITH,
        SEL_LOGIC,
        SEL_SHIFT
    } alu_sel_e;

    // one entry of the instruction buffer
    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
    } instr_info_t;

    // 2RI8, bits 31:18
    localparam logic [13:0] OPC_SLLI_W = 14'h0010;
    localparam logic [13:0] OPC_SRLI_W = 14'h0011;
    localparam logic [13:0] OPC_SRAI_W = 14'h0012;

    // 3R, bits 31:15
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    localparam logic [16:0] OPC_SLL_W  = 17'h0002e;

    // 2RI12, bits 31:22
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_ANDI   = 10'h00d;
    localparam logic [9:0]  OPC_ORI    = 10'h00e;
    localparam logic [9:0]  OPC_XORI   = 10'h00f;

    localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

// ==== rtl/decode_if.sv ====
`timescale 1ns/100ps

interface decode_if;

    import core_pkg::*;

    logic      valid;
    // bit 0 reads rj, bit 1 reads rk
    logic [1:0] reg_read_valid;
    reg_addr_t rj_addr;
    reg_addr_t rk_addr;
    data_t     imm;
    // second ALU operand comes from imm instead of rk
    logic      use_imm;
    logic      reg_write_valid;
    reg_addr_t rd_addr;
    alu_op_e   alu_op;
    alu_sel_e  alu_sel;

    modport producer (
        output valid, reg_read_valid, rj_addr, rk_addr, imm, use_imm,
        output reg_write_valid, rd_addr, alu_op, alu_sel
    );

    modport consumer (
        input valid, reg_read_valid, rj_addr, rk_addr, imm, use_imm,
        input reg_write_valid, rd_addr, alu_op, alu_sel
    );

endinterface

// ==== rtl/decoder_2ri12.sv ====
`timescale 1ns/100ps

// 2RI12 layout {opcode[9:0], imm12, rj, rd}
module decoder_2ri12 (
    input  core_pkg::instr_info_t instr_info_i,
    decode_if.producer            dec_o
);

    import core_pkg::*;

    instr_t      instr;
    logic [11:0] imm12;
    data_t       imm_sext;
    data_t       imm_zext;

    assign instr    = instr_info_i.instr;
    assign imm12    = instr[21:10];
    assign imm_sext = {{20{imm12[11]}}, imm12};
    assign imm_zext = {20'b0, imm12};

    always_comb begin
        dec_o.valid           = instr_info_i.valid;
        dec_o.reg_read_valid  = 2'b01;
        dec_o.rj_addr         = instr[9:5];
        dec_o.rk_addr         = '0;
        // logic forms take the zero-extended value
        dec_o.imm             = imm_zext;
        dec_o.use_imm         = 1'b1;
        dec_o.reg_write_valid = 1'b1;
        dec_o.rd_addr         = instr[4:0];
        dec_o.alu_op          = ALU_AND;
        dec_o.alu_sel         = SEL_LOGIC;
        case (instr[31:22])
            OPC_ADDI_W: begin
                dec_o.imm     = imm_sext;
                dec_o.alu_op  = ALU_ADD;
                dec_o.alu_sel = SEL_ARITH;
            end
            OPC_ANDI: begin
                dec_o.alu_op = ALU_AND;
            end
            OPC_ORI: begin
                dec_o.alu_op = ALU_OR;
            end
            OPC_XORI: begin
                dec_o.alu_op = ALU_XOR;
            end
            default: begin
                dec_o.valid = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/decoder_2ri8.sv ====
`timescale 1ns/100ps

// 2RI8 layout {opcode[13:0], imm8, rj, rd}
module decoder_2ri8 (
    input  core_pkg::instr_info_t instr_info_i,
    decode_if.producer            dec_o
);

    import core_pkg::*;

    instr_t    instr;
    logic [7:0] imm8;

    assign instr = instr_info_i.instr;
    assign imm8  = instr[17:10];

    always_comb begin
        // shared by all three shifts
        dec_o.valid           = instr_info_i.valid;
        dec_o.reg_read_valid  = 2'b01;
        dec_o.rj_addr         = instr[9:5];
        dec_o.rk_addr         = '0;
        // only the low five bits are a shift amount
        dec_o.imm             = {27'b0, imm8[4:0]};
        dec_o.use_imm         = 1'b1;
        dec_o.reg_write_valid = 1'b1;
        dec_o.rd_addr         = instr[4:0];
        dec_o.alu_op          = ALU_SLL;
        dec_o.alu_sel         = SEL_SHIFT;
        case (instr[31:18])
            OPC_SLLI_W: begin
                dec_o.alu_op = ALU_SLL;
            end
            OPC_SRLI_W: begin
                dec_o.alu_op = ALU_SRL;
            end
            OPC_SRAI_W: begin
                dec_o.alu_op = ALU_SRA;
            end
            default: begin
                dec_o.valid = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/decoder_3r.sv ====
`timescale 1ns/100ps

// 3R layout {opcode[16:0], rk, rj, rd}
module decoder_3r (
    input  core_pkg::instr_info_t instr_info_i,
    decode_if.producer            dec_o
);

    import core_pkg::*;

    instr_t instr;

    assign instr = instr_info_i.instr;

    always_comb begin
        dec_o.valid           = instr_info_i.valid;
        dec_o.reg_read_valid  = 2'b11;
        dec_o.rj_addr         = instr[9:5];
        dec_o.rk_addr         = instr[14:10];
        dec_o.imm             = '0;
        dec_o.use_imm         = 1'b0;
        dec_o.reg_write_valid = 1'b1;
        dec_o.rd_addr         = instr[4:0];
        dec_o.alu_op          = ALU_ADD;
        dec_o.alu_sel         = SEL_ARITH;
        case (instr[31:15])
            OPC_ADD_W: begin
                dec_o.alu_op = ALU_ADD;
            end
            OPC_SUB_W: begin
                dec_o.alu_op = ALU_SUB;
            end
            OPC_AND: begin
                dec_o.alu_op  = ALU_AND;
                dec_o.alu_sel = SEL_LOGIC;
            end
            OPC_OR: begin
                dec_o.alu_op  = ALU_OR;
                dec_o.alu_sel = SEL_LOGIC;
            end
            OPC_XOR: begin
                dec_o.alu_op  = ALU_XOR;
                dec_o.alu_sel = SEL_LOGIC;
            end
            OPC_SLL_W: begin
                // shift amount is rk[4:0], taken in the ALU
                dec_o.alu_op  = ALU_SLL;
                dec_o.alu_sel = SEL_SHIFT;
            end
            default: begin
                dec_o.valid = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/fetch_wb.sv ====
`timescale 1ns/100ps

module fetch_wb (
    input  logic                  clk,
    input  logic                  reset_i,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic                  wb_we_o,
    output core_pkg::addr_t       wb_adr_o,
    input  core_pkg::instr_t      wb_dat_i,
    input  logic                  wb_ack_i,
    output core_pkg::instr_info_t instr_info_o
);

    import core_pkg::*;

    typedef enum logic {
        ST_REQ,
        ST_GAP
    } fetch_state_e;

    fetch_state_e state_q;
    addr_t        pc_q;
    logic         ack_hit;
    logic         buf_valid_q;
    addr_t        buf_pc_q;
    instr_t       buf_instr_q;

    assign ack_hit = (state_q == ST_REQ) && wb_ack_i;

    // gap after reset, so the first request follows release
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= ST_GAP;
            pc_q        <= RESET_PC;
            buf_valid_q <= 1'b0;
        end else begin
            buf_valid_q <= ack_hit;
            case (state_q)
                ST_REQ: begin
                    if (wb_ack_i) begin
                        state_q <= ST_GAP;
                        pc_q    <= pc_q + 32'd4;
                    end
                end
                default: begin
                    state_q <= ST_REQ;
                end
            endcase
        end
    end

    // instruction buffer payload
    always_ff @(posedge clk) begin
        if (ack_hit) begin
            buf_pc_q    <= pc_q;
            buf_instr_q <= wb_dat_i;
        end
    end

    // read-only master
    assign wb_cyc_o = (state_q == ST_REQ);
    assign wb_stb_o = (state_q == ST_REQ);
    assign wb_we_o  = 1'b0;
    assign wb_adr_o = pc_q;

    assign instr_info_o = '{valid: buf_valid_q, pc: buf_pc_q, instr: buf_instr_q};

endmodule

// ==== rtl/gpr_file.sv ====
`timescale 1ns/100ps

module gpr_file (
    input  logic                clk,
    input  logic                reset_i,
    input  core_pkg::reg_addr_t rj_addr_i,
    input  core_pkg::reg_addr_t rk_addr_i,
    output core_pkg::data_t     rj_data_o,
    output core_pkg::data_t     rk_data_o,
    input  logic                we_i,
    input  core_pkg::reg_addr_t wd_addr_i,
    input  core_pkg::data_t     wd_data_i
);

    import core_pkg::*;

    data_t regs [GPR_NUM];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wd_addr_i != '0)) begin
            // r0 is never written
            regs[wd_addr_i] <= wd_data_i;
        end
    end

    // r0 reads as zero
    assign rj_data_o = (rj_addr_i == '0) ? '0 : regs[rj_addr_i];
    assign rk_data_o = (rk_addr_i == '0) ? '0 : regs[rk_addr_i];

endmodule

// ==== rtl/id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
    input  logic                  clk,
    input  logic                  reset_i,
    input  core_pkg::instr_info_t instr_info_i,
    output core_pkg::addr_t       pc_o,
    output logic                  illegal_o,
    decode_if.producer            dec_o
);

    import core_pkg::*;

    logic any_valid;

    decode_if dec_2ri8 ();
    decode_if dec_3r ();
    decode_if dec_2ri12 ();

    decoder_2ri8 u_decoder_2ri8 (
        .instr_info_i (instr_info_i),
        .dec_o        (dec_2ri8)
    );

    decoder_3r u_decoder_3r (
        .instr_info_i (instr_info_i),
        .dec_o        (dec_3r)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_info_i (instr_info_i),
        .dec_o        (dec_2ri12)
    );

    // opcode fields are disjoint, at most one decoder hits
    assign any_valid = dec_2ri8.valid | dec_3r.valid | dec_2ri12.valid;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_o.valid <= 1'b0;
            illegal_o   <= 1'b0;
        end else begin
            dec_o.valid <= any_valid;
            illegal_o   <= instr_info_i.valid & ~any_valid;
        end
    end

    // payload follows the valid decoder, 2RI8 when none hits
    always_ff @(posedge clk) begin
        pc_o <= instr_info_i.pc;
        if (dec_3r.valid) begin
            dec_o.reg_read_valid  <= dec_3r.reg_read_valid;
            dec_o.rj_addr         <= dec_3r.rj_addr;
            dec_o.rk_addr         <= dec_3r.rk_addr;
            dec_o.imm             <= dec_3r.imm;
            dec_o.use_imm         <= dec_3r.use_imm;
            dec_o.reg_write_valid <= dec_3r.reg_write_valid;
            dec_o.rd_addr         <= dec_3r.rd_addr;
            dec_o.alu_op          <= dec_3r.alu_op;
            dec_o.alu_sel         <= dec_3r.alu_sel;
        end else if (dec_2ri12.valid) begin
            dec_o.reg_read_valid  <= dec_2ri12.reg_read_valid;
            dec_o.rj_addr         <= dec_2ri12.rj_addr;
            dec_o.rk_addr         <= dec_2ri12.rk_addr;
            dec_o.imm             <= dec_2ri12.imm;
            dec_o.use_imm         <= dec_2ri12.use_imm;
            dec_o.reg_write_valid <= dec_2ri12.reg_write_valid;
            dec_o.rd_addr         <= dec_2ri12.rd_addr;
            dec_o.alu_op          <= dec_2ri12.alu_op;
            dec_o.alu_sel         <= dec_2ri12.alu_sel;
        end else begin
            dec_o.reg_read_valid  <= dec_2ri8.reg_read_valid;
            dec_o.rj_addr         <= dec_2ri8.rj_addr;
            dec_o.rk_addr         <= dec_2ri8.rk_addr;
            dec_o.imm             <= dec_2ri8.imm;
            dec_o.use_imm         <= dec_2ri8.use_imm;
            dec_o.reg_write_valid <= dec_2ri8.reg_write_valid;
            dec_o.rd_addr         <= dec_2ri8.rd_addr;
            dec_o.alu_op          <= dec_2ri8.alu_op;
            dec_o.alu_sel         <= dec_2ri8.alu_sel;
        end
    end

endmodule

// ==== rtl/la_core_top.sv ====
`timescale 1ns/100ps

module la_core_top (
    input  logic                clk,
    input  logic                reset_i,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output core_pkg::addr_t     wb_adr_o,
    input  core_pkg::instr_t    wb_dat_i,
    input  logic                wb_ack_i,
    output logic                commit_valid_o,
    output core_pkg::addr_t     commit_pc_o,
    output core_pkg::reg_addr_t commit_rd_o,
    output core_pkg::data_t     commit_data_o,
    output logic                illegal_o
);

    import core_pkg::*;

    instr_info_t instr_info;
    data_t       rj_data;
    data_t       rk_data;
    data_t       alu_b;
    logic        gpr_we;

    decode_if dec ();

    fetch_wb u_fetch_wb (
        .clk          (clk),
        .reset_i      (reset_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .instr_info_o (instr_info)
    );

    id_stage u_id_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .instr_info_i (instr_info),
        .pc_o         (commit_pc_o),
        .illegal_o    (illegal_o),
        .dec_o        (dec)
    );

    // execute and write back in one cycle
    assign alu_b  = dec.use_imm ? dec.imm : rk_data;
    assign gpr_we = dec.valid & dec.reg_write_valid;

    gpr_file u_gpr_file (
        .clk       (clk),
        .reset_i   (reset_i),
        .rj_addr_i (dec.rj_addr),
        .rk_addr_i (dec.rk_addr),
        .rj_data_o (rj_data),
        .rk_data_o (rk_data),
        .we_i      (gpr_we),
        .wd_addr_i (dec.rd_addr),
        .wd_data_i (commit_data_o)
    );

    alu u_alu (
        .op_i     (dec.alu_op),
        .sel_i    (dec.alu_sel),
        .a_i      (rj_data),
        .b_i      (alu_b),
        .result_o (commit_data_o)
    );

    assign commit_valid_o = gpr_we;
    assign commit_rd_o    = dec.rd_addr;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_top -f compile.f \
    --Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== test/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;

    import core_pkg::*;

    localparam int MEM_WORDS = 128;
    localparam logic [13:0] SHIFT_OPCS [3] = '{OPC_SLLI_W, OPC_SRLI_W, OPC_SRAI_W};
    localparam logic [16:0] RR_OPCS [6] = '{OPC_ADD_W, OPC_SUB_W, OPC_AND, OPC_OR,
                                            OPC_XOR, OPC_SLL_W};
    localparam logic [9:0]  RI_OPCS [4] = '{OPC_ADDI_W, OPC_ANDI, OPC_ORI, OPC_XORI};

    logic      clk = 1'b0;
    logic      reset_i = 1'b1;
    logic      wb_cyc_o;
    logic      wb_stb_o;
    logic      wb_we_o;
    addr_t     wb_adr_o;
    instr_t    wb_dat_i = '0;
    logic      wb_ack_i = 1'b0;
    logic      commit_valid_o;
    addr_t     commit_pc_o;
    reg_addr_t commit_rd_o;
    data_t     commit_data_o;
    logic      illegal_o;

    // program image, memory contents and reference register state
    instr_t    prog [MEM_WORDS];
    instr_t    mem [MEM_WORDS];
    data_t     ref_regs [GPR_NUM];
    int        prog_len = 0;
    int        mem_words = 0;
    // predicted events in program order
    logic      exp_legal_q [$];
    addr_t     exp_pc_q [$];
    reg_addr_t exp_rd_q [$];
    data_t     exp_data_q [$];
    int        delay_q [$];
    int        ack_cycle_q [$];
    string     cur_test = "none";
    int        max_delay = 0;
    int        total_instr = 0;
    int        cycle_cnt = 0;
    int        wd_cycles = 0;
    int        wait_left = 0;
    logic      in_req = 1'b0;

    la_core_top DUT (
        .clk            (clk),
        .reset_i        (reset_i),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .illegal_o      (illegal_o)
    );

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", cur_test, msg);
        stop_run();
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s %s expected %08h actual %08h", cur_test, what, exp, act);
            stop_run();
        end
    endtask

    task automatic record_instr(input instr_t word, input logic legal,
                                input reg_addr_t rd, input data_t value);
        exp_legal_q.push_back(legal);
        exp_pc_q.push_back(RESET_PC + 32'(prog_len * 4));
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(value);
        prog[prog_len] = word;
        prog_len++;
        total_instr++;
        // r0 keeps zero in the reference too
        if (legal && rd != 5'd0) begin
            ref_regs[rd] = value;
        end
    endtask

    task automatic shift_instr(input logic [13:0] opc, input reg_addr_t rd,
                               input reg_addr_t rj, input logic [7:0] imm8);
        data_t src;
        data_t res;
        int    sa;
        src = ref_regs[rj];
        sa  = int'(imm8) % 32;
        res = src >> sa;
        if (opc == OPC_SLLI_W) begin
            res = src << sa;
        end else if (opc == OPC_SRAI_W && src[31]) begin
            // fill vacated high bits with the sign
            res = res | ~(32'hffff_ffff >> sa);
        end
        record_instr({opc, imm8, rj, rd}, 1'b1, rd, res);
    endtask

    task automatic three_reg_instr(input logic [16:0] opc, input reg_addr_t rd,
                                   input reg_addr_t rj, input reg_addr_t rk);
        data_t a;
        data_t b;
        data_t res;
        a = ref_regs[rj];
        b = ref_regs[rk];
        case (opc)
            OPC_ADD_W: res = a + b;
            OPC_SUB_W: res = a - b;
            OPC_AND:   res = a & b;
            OPC_OR:    res = a | b;
            OPC_XOR:   res = a ^ b;
            default:   res = a << (b % 32);
        endcase
        record_instr({opc, rk, rj, rd}, 1'b1, rd, res);
    endtask

    task automatic imm12_instr(input logic [9:0] opc, input reg_addr_t rd,
                               input reg_addr_t rj, input logic [11:0] imm12);
        data_t a;
        data_t ext;
        data_t res;
        a   = ref_regs[rj];
        ext = {20'h0, imm12};
        if (opc == OPC_ADDI_W && imm12[11]) begin
            ext = ext | 32'hffff_f000;
        end
        case (opc)
            OPC_ADDI_W: res = a + ext;
            OPC_ANDI:   res = a & ext;
            OPC_ORI:    res = a | ext;
            default:    res = a ^ ext;
        endcase
        record_instr({opc, imm12, rj, rd}, 1'b1, rd, res);
    endtask

    task automatic illegal_instr(input instr_t word);
        record_instr(word, 1'b0, 5'd0, '0);
    endtask

    task automatic start_test(input string name, input int delay);
        cur_test  = name;
        max_delay = delay;
        prog_len  = 0;
        mem_words = 0;
        for (int i = 0; i < GPR_NUM; i++) begin
            ref_regs[i] = '0;
        end
        exp_legal_q.delete();
        exp_pc_q.delete();
        exp_rd_q.delete();
        exp_data_q.delete();
    endtask

    // reset, load the program, then wait until every prediction is matched
    task automatic run_program();
        @(negedge clk);
        reset_i = 1'b1;
        ack_cycle_q.delete();
        delay_q.delete();
        for (int i = 0; i < prog_len; i++) begin
            mem[i] = prog[i];
            delay_q.push_back(int'($urandom % (max_delay + 1)));
        end
        repeat (4) @(negedge clk);
        check_value("cyc in reset", 32'd0, 32'(wb_cyc_o));
        check_value("stb in reset", 32'd0, 32'(wb_stb_o));
        check_value("commit in reset", 32'd0, 32'(commit_valid_o));
        check_value("illegal in reset", 32'd0, 32'(illegal_o));
        mem_words = prog_len;
        reset_i   = 1'b0;
        @(negedge clk);
        check_value("first cyc", 32'd1, 32'(wb_cyc_o));
        check_value("first address", RESET_PC, wb_adr_o);
        while (exp_legal_q.size() != 0) begin
            @(negedge clk);
        end
        // no stray events once the program is done
        repeat (4) @(negedge clk);
    endtask

    task automatic check_event();
        logic      legal;
        addr_t     pc;
        reg_addr_t rd;
        data_t     value;
        int        ack_cycle;
        if (exp_legal_q.size() == 0 || ack_cycle_q.size() == 0) begin
            report_error("commit port event with no instruction outstanding");
        end else begin
            legal     = exp_legal_q.pop_front();
            pc        = exp_pc_q.pop_front();
            rd        = exp_rd_q.pop_front();
            value     = exp_data_q.pop_front();
            ack_cycle = ack_cycle_q.pop_front();
            if (commit_valid_o && illegal_o) begin
                report_error("commit_valid_o and illegal_o high in the same cycle");
            end else if (legal && illegal_o) begin
                report_error("legal instruction was flagged illegal");
            end else if (!legal && commit_valid_o) begin
                report_error("illegal instruction was committed");
            end else begin
                check_value("pc", pc, commit_pc_o);
                // ack presented, then two edges until the commit is visible
                check_value("latency", 32'd2, 32'(cycle_cnt - ack_cycle));
                if (legal) begin
                    check_value("rd", 32'(rd), 32'(commit_rd_o));
                    check_value("data", value, commit_data_o);
                end
            end
        end
    endtask

    // monitor first, then the memory model drives its inputs
    always @(negedge clk) begin
        cycle_cnt++;
        if (!reset_i && (commit_valid_o || illegal_o)) begin
            check_event();
        end
        // stb goes with cyc and we stays low
        if (!reset_i && wb_cyc_o) begin
            check_value("stb during cycle", 32'd1, 32'(wb_stb_o));
            check_value("we during cycle", 32'd0, 32'(wb_we_o));
        end
        if (reset_i) begin
            wb_ack_i = 1'b0;
            in_req   = 1'b0;
        end else if (wb_ack_i) begin
            wb_ack_i = 1'b0;
        end else if (wb_cyc_o && wb_stb_o && int'(wb_adr_o >> 2) < mem_words) begin
            if (!in_req) begin
                in_req    = 1'b1;
                wait_left = delay_q.pop_front();
            end
            if (wait_left == 0) begin
                wb_ack_i = 1'b1;
                wb_dat_i = mem[int'(wb_adr_o >> 2)];
                in_req   = 1'b0;
                ack_cycle_q.push_back(cycle_cnt);
            end else begin
                wait_left--;
            end
        end
    end

    // watchdog, limit grows as tests add instructions
    always @(posedge clk) begin
        wd_cycles++;
        if (wd_cycles > total_instr * 8 + 100) begin
            $display("ERROR: watchdog expired in %s after %0d cycles", cur_test, wd_cycles);
            stop_run();
        end
    end

    task automatic reset_latency();
        start_test("reset_latency", 0);
        imm12_instr(OPC_ADDI_W, 5'd1, 5'd0, 12'h005);
        imm12_instr(OPC_ADDI_W, 5'd2, 5'd1, 12'hfff);
        three_reg_instr(OPC_ADD_W, 5'd3, 5'd1, 5'd2);
        run_program();
    endtask

    task automatic shifts_by_imm();
        start_test("shifts_by_imm", 3);
        imm12_instr(OPC_ADDI_W, 5'd1, 5'd0, 12'h810);
        imm12_instr(OPC_ORI, 5'd2, 5'd0, 12'h5a3);
        shift_instr(OPC_SLLI_W, 5'd3, 5'd2, 8'd4);
        shift_instr(OPC_SRLI_W, 5'd4, 5'd1, 8'd31);
        shift_instr(OPC_SRAI_W, 5'd5, 5'd1, 8'd31);
        shift_instr(OPC_SRAI_W, 5'd6, 5'd1, 8'd3);
        shift_instr(OPC_SRLI_W, 5'd7, 5'd1, 8'd0);
        // upper imm8 bits set, only bits 4:0 count
        shift_instr(OPC_SLLI_W, 5'd8, 5'd2, 8'he3);
        shift_instr(OPC_SRAI_W, 5'd9, 5'd1, 8'hff);
        shift_instr(OPC_SRLI_W, 5'd10, 5'd2, 8'h25);
        run_program();
    endtask

    task automatic reg_reg_ops();
        start_test("reg_reg_ops", 3);
        imm12_instr(OPC_ADDI_W, 5'd1, 5'd0, 12'h007);
        imm12_instr(OPC_ADDI_W, 5'd2, 5'd0, 12'hffd);
        three_reg_instr(OPC_ADD_W, 5'd3, 5'd1, 5'd2);
        three_reg_instr(OPC_SUB_W, 5'd4, 5'd0, 5'd1);
        three_reg_instr(OPC_SUB_W, 5'd5, 5'd2, 5'd1);
        three_reg_instr(OPC_AND, 5'd6, 5'd1, 5'd2);
        three_reg_instr(OPC_OR, 5'd7, 5'd1, 5'd2);
        three_reg_instr(OPC_XOR, 5'd8, 5'd1, 5'd2);
        // 35 in rk, shift by 3
        imm12_instr(OPC_ADDI_W, 5'd9, 5'd0, 12'h023);
        three_reg_instr(OPC_SLL_W, 5'd10, 5'd1, 5'd9);
        three_reg_instr(OPC_ADD_W, 5'd11, 5'd10, 5'd10);
        three_reg_instr(OPC_SUB_W, 5'd12, 5'd11, 5'd3);
        run_program();
    endtask

    task automatic imm_extension();
        start_test("imm_extension", 2);
        imm12_instr(OPC_ADDI_W, 5'd1, 5'd0, 12'h800);
        imm12_instr(OPC_ADDI_W, 5'd2, 5'd1, 12'h7ff);
        imm12_instr(OPC_ADDI_W, 5'd3, 5'd2, 12'hfff);
        imm12_instr(OPC_ANDI, 5'd4, 5'd1, 12'hf0f);
        imm12_instr(OPC_ORI, 5'd5, 5'd0, 12'h800);
        imm12_instr(OPC_XORI, 5'd6, 5'd1, 12'hfff);
        imm12_instr(OPC_ANDI, 5'd7, 5'd3, 12'h8ff);
        run_program();
    endtask

    task automatic r0_and_illegal();
        start_test("r0_and_illegal", 1);
        imm12_instr(OPC_ADDI_W, 5'd0, 5'd0, 12'h123);
        three_reg_instr(OPC_ADD_W, 5'd1, 5'd0, 5'd0);
        imm12_instr(OPC_ADDI_W, 5'd2, 5'd0, 12'h055);
        // rd field points at r2, which must stay unchanged
        illegal_instr(32'hfffc_0042);
        imm12_instr(OPC_ADDI_W, 5'd3, 5'd2, 12'h001);
        three_reg_instr(OPC_ADD_W, 5'd4, 5'd0, 5'd3);
        run_program();
    endtask

    task automatic random_stream();
        logic [31:0] r;
        logic [31:0] v;
        start_test("random_stream", 3);
        for (int i = 1; i < 8; i++) begin
            v = $urandom;
            imm12_instr(OPC_ADDI_W, reg_addr_t'(i), 5'd0, v[11:0]);
        end
        for (int i = 0; i < 50; i++) begin
            r = $urandom;
            v = $urandom;
            case (r % 3)
                0: shift_instr(SHIFT_OPCS[v % 3], r[4:0], r[9:5], v[31:24]);
                1: three_reg_instr(RR_OPCS[v % 6], r[4:0], r[9:5], r[14:10]);
                default: imm12_instr(RI_OPCS[v % 4], r[4:0], r[9:5], v[27:16]);
            endcase
        end
        run_program();
    endtask

    initial begin
        void'($urandom(32'hcb5b));
        reset_latency();
        shifts_by_imm();
        reg_reg_ops();
        imm_extension();
        r0_and_illegal();
        random_stream();
        $display("Test OK");
        $finish;
    end

endmodule
